/* source/phy_pkg.sv */
package phy_pkg;

    // UART oversampling on the carrier clock
    localparam int CLKS_PER_BIT = 8;
    localparam int HALF_BIT = CLKS_PER_BIT / 2;
    localparam int BIT_CNT_WIDTH = $clog2(CLKS_PER_BIT);

    // DAC bus driven onto pio
    localparam int DAC_WIDTH = 8;

    // Carrier levels for a 1 bit
    localparam logic [DAC_WIDTH-1:0] DAC_HIGH = 8'hFF;
    localparam logic [DAC_WIDTH-1:0] DAC_LOW = 8'h00;

    // Level for a 0 bit and for an idle line
    localparam logic [DAC_WIDTH-1:0] DAC_MID = 8'h80;

    // Carrier samples per frame bit
    localparam int SAMPLES_PER_BIT = 4;
    localparam int SAMPLE_CNT_WIDTH = $clog2(SAMPLES_PER_BIT);

    // Receiver states
    typedef enum logic [1:0] {
        U_IDLE,
        U_START,
        U_DATA,
        U_STOP
    } uart_state_e;

endpackage

/* source/tx_pkg.sv */
package tx_pkg;

    // Packet geometry
    localparam int PACKET_BYTES = 4;
    localparam int INDEX_WIDTH = 2;

    // Frame header
    localparam int PREAMBLE_BITS = 8;
    localparam logic [PREAMBLE_BITS-1:0] PREAMBLE = 8'hA5;

    // One tagged byte on the wire
    localparam int FIELD_BITS = INDEX_WIDTH + 8;

    // Whole frame, 48 bits
    localparam int FRAME_BITS = PREAMBLE_BITS + PACKET_BYTES * FIELD_BITS;
    localparam int FRAME_CNT_WIDTH = $clog2(FRAME_BITS);

    // Byte 0 is the first byte received
    typedef struct packed {
        logic [PACKET_BYTES-1:0][7:0] bytes;
    } packet_t;

    // Index goes out ahead of the data
    typedef struct packed {
        logic [INDEX_WIDTH-1:0] index;
        logic [7:0]             data;
    } field_t;

    // Ascending range puts field 0 right after the preamble, MSB first
    typedef struct packed {
        logic [PREAMBLE_BITS-1:0]  preamble;
        field_t [0:PACKET_BYTES-1] fields;
    } frame_t;

    // Control sequencing
    typedef enum logic [1:0] {
        S_IDLE,
        S_SORT,
        S_SEND
    } tx_state_e;

endpackage

/* source/uart_rx.sv */
module uart_rx
    import phy_pkg::*;
(
    input  logic       clk_carrier,
    input  logic       rst_n,
    input  logic       uart_txd_in,
    output logic [7:0] byte_data,
    output logic       byte_valid
);

    logic                     rx_meta;
    logic                     rx_sync;
    logic                     rx_prev;
    logic                     start_edge;
    logic                     bit_end;
    uart_state_e              state;
    logic [BIT_CNT_WIDTH-1:0] clk_cnt;
    logic [2:0]               bit_idx;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_txd_in;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev && !rx_sync;
    assign bit_end = (clk_cnt == BIT_CNT_WIDTH'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            state      <= U_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                U_IDLE: begin
                    bit_idx <= '0;
                    clk_cnt <= '0;
                    if (start_edge) begin
                        // Edge cycle already counts as the first start sample
                        clk_cnt <= BIT_CNT_WIDTH'(1);
                        state   <= U_START;
                    end
                end
                U_START: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == BIT_CNT_WIDTH'(HALF_BIT - 1)) begin
                        clk_cnt <= '0;
                        // Glitch rejection at mid start bit
                        state <= rx_sync ? U_IDLE : U_DATA;
                    end
                end
                U_DATA: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= U_STOP;
                        end
                    end
                end
                U_STOP: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (bit_end) begin
                        byte_valid <= rx_sync;  // framing error drops the byte
                        state      <= U_IDLE;
                    end
                end
                default: state <= U_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk_carrier) begin
        if (state == U_DATA && bit_end) begin
            byte_data <= {rx_sync, byte_data[7:1]};
        end
    end

    a_valid_single: assert property (@(posedge clk_carrier) disable iff (!rst_n)
        byte_valid |=> !byte_valid);

endmodule

/* source/byte_packet_buffer.sv */
module byte_packet_buffer
    import tx_pkg::*;
(
    input  logic       clk_carrier,
    input  logic       rst_n,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    input  logic       take,
    output packet_t    packet,
    output logic       full,
    output logic       overrun
);

    logic [INDEX_WIDTH-1:0] count;
    logic                   write_en;

    // A full packet blocks further writes until it is taken
    assign write_en = byte_valid && !full;

    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            count   <= '0;
            full    <= 1'b0;
            overrun <= 1'b0;
        end else begin
            overrun <= byte_valid && full;
            if (take) begin
                count <= '0;
                full  <= 1'b0;
            end else if (write_en) begin
                count <= count + 1'b1;
                if (count == INDEX_WIDTH'(PACKET_BYTES - 1)) begin
                    full <= 1'b1;
                end
            end
        end
    end

    // Slot storage
    always_ff @(posedge clk_carrier) begin
        if (write_en) begin
            packet.bytes[count] <= byte_data;
        end
    end

    a_take_when_full: assert property (@(posedge clk_carrier) disable iff (!rst_n)
        take |-> full);

endmodule

/* source/packet_sorter.sv */
module packet_sorter
    import tx_pkg::*;
(
    input  logic    clk_carrier,
    input  logic    rst_n,
    input  logic    take,
    input  packet_t packet,
    output frame_t  frame,
    output logic    sort_done
);

    packet_t                pkt_q;
    logic                   busy;
    logic [INDEX_WIDTH-1:0] idx;

    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            idx       <= '0;
            sort_done <= 1'b0;
        end else begin
            sort_done <= 1'b0;
            if (take) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (busy) begin
                idx <= idx + 1'b1;
                if (idx == INDEX_WIDTH'(PACKET_BYTES - 1)) begin
                    busy      <= 1'b0;
                    sort_done <= 1'b1;
                end
            end
        end
    end

    // Snapshot on take so the buffer can refill
    always_ff @(posedge clk_carrier) begin
        if (take) begin
            pkt_q <= packet;
        end
    end

    // One tagged field per cycle, preamble at the head
    always_ff @(posedge clk_carrier) begin
        if (take) begin
            frame.preamble <= PREAMBLE;
        end
        if (busy) begin
            frame.fields[idx].index <= idx;
            frame.fields[idx].data  <= pkt_q.bytes[idx];
        end
    end

endmodule

/* source/signal_modulator.sv */
module signal_modulator
    import phy_pkg::*;
    import tx_pkg::*;
(
    input  logic                 clk_carrier,
    input  logic                 rst_n,
    input  logic                 mod_start,
    input  frame_t               frame,
    output logic [DAC_WIDTH-1:0] pio,
    output logic                 tx_active,
    output logic                 mod_done
);

    logic [FRAME_BITS-1:0]       shift_q;
    logic [SAMPLE_CNT_WIDTH-1:0] sample_cnt;
    logic [FRAME_CNT_WIDTH-1:0]  bit_cnt;
    logic                        last_sample;
    logic                        last_bit;
    logic                        carrier_phase;
    logic                        cur_bit;

    assign last_sample = (sample_cnt == SAMPLE_CNT_WIDTH'(SAMPLES_PER_BIT - 1));
    assign last_bit = (bit_cnt == FRAME_CNT_WIDTH'(FRAME_BITS - 1));
    assign mod_done = tx_active && last_sample && last_bit;

    // Phase toggles every sample, starting high
    assign carrier_phase = sample_cnt[0];
    assign cur_bit = shift_q[FRAME_BITS-1];

    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            tx_active  <= 1'b0;
            sample_cnt <= '0;
            bit_cnt    <= '0;
        end else if (mod_start) begin
            tx_active  <= 1'b1;
            sample_cnt <= '0;
            bit_cnt    <= '0;
        end else if (tx_active) begin
            sample_cnt <= sample_cnt + 1'b1;
            if (last_sample) begin
                sample_cnt <= '0;
                bit_cnt    <= bit_cnt + 1'b1;
                if (last_bit) begin
                    tx_active <= 1'b0;
                end
            end
        end
    end

    // Frame goes out MSB first
    always_ff @(posedge clk_carrier) begin
        if (mod_start) begin
            shift_q <= frame;
        end else if (tx_active && last_sample) begin
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
        end
    end

    // On-off keying around the mid level
    always_comb begin
        if (!tx_active || !cur_bit) begin
            pio = DAC_MID;
        end else if (carrier_phase) begin
            pio = DAC_LOW;
        end else begin
            pio = DAC_HIGH;
        end
    end

    a_start_when_idle: assert property (@(posedge clk_carrier) disable iff (!rst_n)
        mod_start |-> !tx_active);

endmodule

/* source/tx_control.sv */
module tx_control
    import tx_pkg::*;
(
    input  logic clk_carrier,
    input  logic rst_n,
    input  logic full,
    input  logic sort_done,
    input  logic mod_done,
    output logic take,
    output logic mod_start
);

    tx_state_e state;

    // One frame in the sorter and one in the modulator at most
    always_ff @(posedge clk_carrier) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            take      <= 1'b0;
            mod_start <= 1'b0;
        end else begin
            take      <= 1'b0;
            mod_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (full) begin
                        take  <= 1'b1;
                        state <= S_SORT;
                    end
                end
                S_SORT: begin
                    if (sort_done) begin
                        mod_start <= 1'b1;
                        state     <= S_SEND;
                    end
                end
                S_SEND: begin
                    // Waiting packet is picked up once back in idle
                    if (mod_done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_done_in_sort: assert property (@(posedge clk_carrier) disable iff (!rst_n)
        sort_done |-> state == S_SORT);

endmodule

/* source/transmitter.sv */
module transmitter
    import phy_pkg::*;
    import tx_pkg::*;
(
    input  logic                 clk_carrier,
    input  logic                 rst_n,
    input  logic                 uart_txd_in,
    output logic [DAC_WIDTH-1:0] pio,
    output logic                 tx_active,
    output logic                 overrun
);

    logic [7:0] byte_data;
    logic       byte_valid;
    packet_t    packet;
    logic       full;
    logic       take;
    frame_t     frame;
    logic       sort_done;
    logic       mod_start;
    logic       mod_done;

    uart_rx u_uart_rx (
        .clk_carrier(clk_carrier),
        .rst_n      (rst_n),
        .uart_txd_in(uart_txd_in),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    byte_packet_buffer u_buffer (
        .clk_carrier(clk_carrier),
        .rst_n      (rst_n),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .take       (take),
        .packet     (packet),
        .full       (full),
        .overrun    (overrun)
    );

    packet_sorter u_sorter (
        .clk_carrier(clk_carrier),
        .rst_n      (rst_n),
        .take       (take),
        .packet     (packet),
        .frame      (frame),
        .sort_done  (sort_done)
    );

    signal_modulator u_modulator (
        .clk_carrier(clk_carrier),
        .rst_n      (rst_n),
        .mod_start  (mod_start),
        .frame      (frame),
        .pio        (pio),
        .tx_active  (tx_active),
        .mod_done   (mod_done)
    );

    tx_control u_control (
        .clk_carrier(clk_carrier),
        .rst_n      (rst_n),
        .full       (full),
        .sort_done  (sort_done),
        .mod_done   (mod_done),
        .take       (take),
        .mod_start  (mod_start)
    );

endmodule

/* test/tb_transmitter.sv */
module tb_transmitter
    import phy_pkg::*;
    import tx_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_SAMPLES = FRAME_BITS * SAMPLES_PER_BIT;
    localparam int RISE_TIMEOUT = 1000;

    logic                 clk_carrier;
    logic                 rst_n;
    logic                 uart_txd_in;
    logic [DAC_WIDTH-1:0] pio;
    logic                 tx_active;
    logic                 overrun;
    integer               seed;

    transmitter uut (
        .clk_carrier(clk_carrier),
        .rst_n      (rst_n),
        .uart_txd_in(uart_txd_in),
        .pio        (pio),
        .tx_active  (tx_active),
        .overrun    (overrun)
    );

    initial begin
        clk_carrier = 1'b0;
        forever #20 clk_carrier = ~clk_carrier;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        assert (actual === expected) else begin
            stop_with_failure($sformatf("Error at %0d ns: %s expected %02h, got %02h",
                                        $time, name, expected, actual));
        end
    endtask

    // No test here can leave a full packet waiting when a byte lands
    always @(negedge clk_carrier) begin
        if (rst_n) begin
            check_value("overrun", 8'h00, {7'b0, overrun});
        end
    end

    // On-off keying, 1 bit alternates high and low starting high
    function automatic logic [DAC_WIDTH-1:0] carrier_level(input logic b, input int sample);
        if (!b) begin
            return DAC_MID;
        end
        return (sample % 2 == 0) ? DAC_HIGH : DAC_LOW;
    endfunction

    // Start bit, 8 data bits LSB first, stop bit
    task automatic send_byte(input logic [7:0] data, input bit bad_stop);
        int i;
        uart_txd_in = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk_carrier);
        for (i = 0; i < 8; i++) begin
            uart_txd_in = data[i];
            repeat (CLKS_PER_BIT) @(negedge clk_carrier);
        end
        uart_txd_in = !bad_stop;
        repeat (CLKS_PER_BIT) @(negedge clk_carrier);
        if (bad_stop) begin
            // Back to idle so the next start bit has an edge
            uart_txd_in = 1'b1;
            repeat (CLKS_PER_BIT) @(negedge clk_carrier);
        end
    endtask

    // Byte i of the packet sits at bits [8i+7:8i]
    task automatic send_packet(input logic [31:0] pkt);
        int i;
        for (i = 0; i < PACKET_BYTES; i++) begin
            send_byte(pkt[i*8 +: 8], 1'b0);
        end
    endtask

    task automatic expect_frame(input logic [31:0] pkt);
        logic [FRAME_BITS-1:0]  bits;
        logic [INDEX_WIDTH-1:0] idx;
        int                     i;
        int                     waited;
        bits = '0;
        bits[FRAME_BITS-1 -: PREAMBLE_BITS] = PREAMBLE;
        for (i = 0; i < PACKET_BYTES; i++) begin
            idx = INDEX_WIDTH'(i);
            bits[FRAME_BITS-1-PREAMBLE_BITS-i*FIELD_BITS -: FIELD_BITS] = {idx, pkt[i*8 +: 8]};
        end
        waited = 0;
        @(negedge clk_carrier);
        while (tx_active !== 1'b1 && waited < RISE_TIMEOUT) begin
            @(negedge clk_carrier);
            waited++;
        end
        assert (tx_active === 1'b1) else begin
            stop_with_failure("Timeout waiting for tx_active to rise for the next frame");
        end
        for (i = 0; i < FRAME_SAMPLES; i++) begin
            check_value("tx_active", 8'h01, {7'b0, tx_active});
            check_value("pio", carrier_level(bits[FRAME_BITS-1-i/SAMPLES_PER_BIT],
                                             i % SAMPLES_PER_BIT), pio);
            @(negedge clk_carrier);
        end
        check_value("tx_active", 8'h00, {7'b0, tx_active});
        check_value("pio", DAC_MID, pio);
    endtask

    task automatic check_idle(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            check_value("tx_active", 8'h00, {7'b0, tx_active});
            check_value("pio", DAC_MID, pio);
            @(negedge clk_carrier);
        end
    endtask

    // Serial stream and frame checks run side by side
    task automatic send_and_check(input logic [3:0][31:0] pkts, input int count);
        int k;
        int j;
        fork
            begin
                for (k = 0; k < count; k++) begin
                    send_packet(pkts[k]);
                end
            end
            begin
                for (j = 0; j < count; j++) begin
                    expect_frame(pkts[j]);
                end
            end
        join
    endtask

    task automatic test_reset_idle();
        check_idle(100);
    endtask

    task automatic test_single_frame();
        send_and_check({96'h0, 32'hFE01C33C}, 1);
        check_idle(20);
    endtask

    task automatic test_random_packets();
        logic [3:0][31:0] pkts;
        int               k;
        pkts = '0;
        for (k = 0; k < 3; k++) begin
            pkts[k] = $random(seed);
        end
        send_and_check(pkts, 3);
        check_idle(20);
    endtask

    task automatic test_second_packet_waits();
        send_and_check({64'h0, 32'h44332211, 32'h0F1E2D3C}, 2);
        check_idle(20);
    endtask

    // A packet needs four byte times, longer than one frame
    task automatic test_burst_of_twelve();
        logic [3:0][31:0] pkts;
        int               k;
        pkts = '0;
        for (k = 0; k < 3; k++) begin
            pkts[k] = $random(seed);
        end
        send_and_check(pkts, 3);
        // Nothing left to send after the third frame
        check_idle(400);
    endtask

    task automatic test_bad_stop_bit();
        send_byte(8'h96, 1'b1);
        send_and_check({96'h0, 32'h7E00B4D2}, 1);
        check_idle(20);
    endtask

    initial begin
        seed = 36;
        rst_n = 1'b0;
        uart_txd_in = 1'b1;
        repeat (16) @(negedge clk_carrier);
        rst_n = 1'b1;
        test_reset_idle();
        test_single_frame();
        test_random_packets();
        test_second_packet_waits();
        test_burst_of_twelve();
        test_bad_stop_bit();
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* project.f */
source/phy_pkg.sv
source/tx_pkg.sv
source/uart_rx.sv
source/byte_packet_buffer.sv
source/packet_sorter.sv
source/signal_modulator.sv
source/tx_control.sv
source/transmitter.sv
test/tb_transmitter.sv

/* Bender.yml */
package:
  name: transmitter

sources:
  - files:
      - source/phy_pkg.sv
      - source/tx_pkg.sv
      - source/uart_rx.sv
      - source/byte_packet_buffer.sv
      - source/packet_sorter.sv
      - source/signal_modulator.sv
      - source/tx_control.sv
      - source/transmitter.sv
  - target: test
    files:
      - test/tb_transmitter.sv
